//--- include/cpu_settings.svh
// word width, address width, register count and reset PC macros for the processor

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and instruction width
`define CPU_WORD_WIDTH 16

// word address width, 512 words of memory
`define CPU_ADDR_WIDTH 9

// general registers r0 to r7
`define CPU_REG_COUNT 8

// first fetch address, also the PC held while halted
`define CPU_RESET_PC 0

`endif

//--- source/cpu_pkg.sv
// shared word, address, register-number and enumerated control types of the processor
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
	typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_num_t;

	// decoded instruction kind, from the opcode/op pair
	typedef enum logic [3:0] {
		cls_mov_imm,
		cls_mov_reg,
		cls_add,
		cls_cmp,
		cls_and_op,
		cls_mvn,
		cls_ldr,
		cls_str,
		cls_branch,
		cls_halt,
		cls_undefined
	} instr_class_t;

	typedef enum logic [1:0] {
		shift_none = 2'b00,
		shift_lsl  = 2'b01, // left by one
		shift_lsr  = 2'b10, // logical right by one
		shift_asr  = 2'b11  // arithmetic right by one
	} shift_t;

	typedef enum logic [1:0] {
		alu_add   = 2'b00,
		alu_sub   = 2'b01,
		alu_and   = 2'b10,
		alu_not_b = 2'b11
	} alu_op_t;

	typedef enum logic [1:0] {
		mem_none  = 2'b00,
		mem_read  = 2'b01,
		mem_write = 2'b10
	} mem_cmd_t;

	typedef enum logic [1:0] {wb_c, wb_imm, wb_mem} wb_sel_t;

	typedef enum logic [1:0] {sel_rn, sel_rd, sel_rm} reg_sel_t;

	typedef enum logic [2:0] {
		cond_always = 3'b000,
		cond_eq     = 3'b001,
		cond_ne     = 3'b010,
		cond_lt     = 3'b011,
		cond_le     = 3'b100
	} branch_cond_t;

endpackage

`default_nettype wire

//--- source/instr_decoder.sv
// instruction register, field extraction, sign extension and instruction classification
`default_nettype none

module instr_decoder (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   load_ir,
	input  wire cpu_pkg::reg_sel_t reg_sel,
	input  wire cpu_pkg::word_t    read_data,
	output cpu_pkg::instr_class_t instr_class,
	output cpu_pkg::reg_num_t     reg_num,
	output cpu_pkg::alu_op_t      alu_op,
	output cpu_pkg::shift_t       shift,
	output cpu_pkg::branch_cond_t cond,
	output cpu_pkg::word_t        sximm5,
	output cpu_pkg::word_t        sximm8
);
	import cpu_pkg::*;

	word_t ir;

	always_ff @(posedge clk) begin
		if (reset) begin
			ir <= '0; // decodes as undefined
		end else if (load_ir) begin
			ir <= read_data;
		end
	end

	always_comb begin
		case ({ir[15:13], ir[12:11]}) // opcode, op
			5'b110_10: instr_class = cls_mov_imm;
			5'b110_00: instr_class = cls_mov_reg;
			5'b101_00: instr_class = cls_add;
			5'b101_01: instr_class = cls_cmp;
			5'b101_10: instr_class = cls_and_op;
			5'b101_11: instr_class = cls_mvn;
			5'b011_00: instr_class = cls_ldr;
			5'b100_00: instr_class = cls_str;
			5'b001_00: instr_class = cls_branch;
			5'b111_00: instr_class = cls_halt;
			default:   instr_class = cls_undefined;
		endcase
	end

	always_comb begin
		case (reg_sel)
			sel_rn:  reg_num = ir[10:8];
			sel_rd:  reg_num = ir[7:5];
			default: reg_num = ir[2:0];
		endcase
	end

	assign alu_op = alu_op_t'(ir[12:11]);
	assign cond = branch_cond_t'(ir[10:8]); // rn field doubles as the condition
	// in LDR and STR bits 4-3 belong to imm5
	assign shift = (instr_class == cls_ldr || instr_class == cls_str) ?
		shift_none : shift_t'(ir[4:3]);
	assign sximm5 = {{($bits(word_t)-5){ir[4]}}, ir[4:0]};
	assign sximm8 = {{($bits(word_t)-8){ir[7]}}, ir[7:0]};

	a_ir_known: assert property (@(posedge clk) disable iff (reset)
		load_ir |=> !$isunknown(ir));

endmodule

`default_nettype wire

//--- source/control_fsm.sv
// fetch/execute sequencer with per-state control outputs and branch condition evaluation
`default_nettype none

module control_fsm (
	input  wire                        clk,
	input  wire                        reset,
	input  wire cpu_pkg::instr_class_t instr_class,
	input  wire cpu_pkg::branch_cond_t cond,
	input  wire                        flag_z,
	input  wire                        flag_n,
	input  wire                        flag_v,
	output cpu_pkg::reg_sel_t          reg_sel,
	output cpu_pkg::wb_sel_t           wb_sel,
	output logic                       load_a,
	output logic                       load_b,
	output logic                       load_c,
	output logic                       load_s,
	output logic                       reg_write,
	output logic                       a_zero,
	output logic                       b_imm,
	output logic                       load_ir,
	output logic                       load_pc,
	output logic                       pc_reset,
	output logic                       take_branch,
	output logic                       load_addr,
	output logic                       addr_sel_pc,
	output cpu_pkg::mem_cmd_t          mem_cmd,
	output logic                       halt
);
	import cpu_pkg::*;

	typedef enum logic [4:0] {
		st_reset, st_fetch1, st_fetch2, st_pc_update,
		st_mov_imm,
		st_mov1, st_mov2, // MOV reg and MVN
		st_alu1, st_alu2, st_alu3, // ADD and AND
		st_cmp1, st_cmp2,
		st_ldr1, st_ldr2, st_ldr3, st_ldr4,
		st_str1, st_str2, st_str3, st_str4, st_str5,
		st_branch,
		st_halt
	} state_t;

	state_t state;
	state_t next_state;
	logic cond_true;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_reset;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			st_reset:     next_state = st_fetch1;
			st_fetch1:    next_state = st_fetch2;
			st_fetch2:    next_state = st_pc_update;
			st_pc_update: begin
				case (instr_class) // IR is valid from this cycle
					cls_mov_imm:          next_state = st_mov_imm;
					cls_mov_reg, cls_mvn: next_state = st_mov1;
					cls_add, cls_and_op:  next_state = st_alu1;
					cls_cmp:              next_state = st_cmp1;
					cls_ldr:              next_state = st_ldr1;
					cls_str:              next_state = st_str1;
					cls_branch:           next_state = st_branch;
					default:              next_state = st_halt; // HALT and undefined
				endcase
			end
			st_mov1:  next_state = st_mov2;
			st_alu1:  next_state = st_alu2;
			st_alu2:  next_state = st_alu3;
			st_cmp1:  next_state = st_cmp2;
			st_ldr1:  next_state = st_ldr2;
			st_ldr2:  next_state = st_ldr3;
			st_ldr3:  next_state = st_ldr4;
			st_str1:  next_state = st_str2;
			st_str2:  next_state = st_str3;
			st_str3:  next_state = st_str4;
			st_str4:  next_state = st_str5;
			st_halt:  next_state = st_halt; // only reset leaves
			st_mov_imm, st_mov2, st_alu3, st_cmp2, st_ldr4, st_str5, st_branch:
				next_state = st_fetch1;
			default:  next_state = st_halt;
		endcase
	end

	always_comb begin
		case (cond)
			cond_always: cond_true = 1'b1;
			cond_eq:     cond_true = flag_z;
			cond_ne:     cond_true = !flag_z;
			cond_lt:     cond_true = flag_n ^ flag_v;
			cond_le:     cond_true = (flag_n ^ flag_v) | flag_z;
			default:     cond_true = 1'b0; // unused codes never branch
		endcase
	end

	always_comb begin
		reg_sel = sel_rn;
		wb_sel = wb_c;
		{load_a, load_b, load_c, load_s, reg_write, a_zero, b_imm} = '0;
		{load_ir, load_pc, pc_reset, take_branch, load_addr, addr_sel_pc} = '0;
		mem_cmd = mem_none;
		halt = 1'b0;
		case (state)
			st_reset: begin
				load_pc = 1'b1;
				pc_reset = 1'b1;
			end
			st_fetch1: begin
				mem_cmd = mem_read;
				addr_sel_pc = 1'b1;
			end
			st_fetch2: begin
				mem_cmd = mem_read;
				addr_sel_pc = 1'b1;
				load_ir = 1'b1;
			end
			st_pc_update: load_pc = 1'b1; // PC + 1
			st_mov_imm: begin
				wb_sel = wb_imm;
				reg_write = 1'b1;
			end
			st_mov1, st_alu2, st_cmp2: begin
				reg_sel = sel_rm;
				load_b = 1'b1;
				load_c = (state != st_cmp2);
				load_s = (state == st_cmp2); // CMP only touches the flags
				a_zero = (state == st_mov1);
			end
			st_alu1, st_cmp1, st_ldr1, st_str1: load_a = 1'b1; // Rn
			st_mov2, st_alu3: begin
				reg_sel = sel_rd;
				reg_write = 1'b1;
			end
			st_ldr2, st_str2: begin
				b_imm = 1'b1; // Rn + sximm5
				load_c = 1'b1;
			end
			st_ldr3: load_addr = 1'b1;
			st_ldr4: begin
				mem_cmd = mem_read;
				reg_sel = sel_rd;
				wb_sel = wb_mem;
				reg_write = 1'b1;
			end
			st_str3: begin
				load_addr = 1'b1;
				reg_sel = sel_rd;
				load_b = 1'b1;
			end
			st_str4: begin
				a_zero = 1'b1; // C = Rd for the write data
				load_c = 1'b1;
			end
			st_str5: mem_cmd = mem_write;
			st_branch: begin
				load_pc = cond_true;
				take_branch = cond_true;
			end
			st_halt: begin
				halt = 1'b1;
				load_pc = 1'b1;
				pc_reset = 1'b1;
			end
			default: ;
		endcase
	end

	// the write address was captured two cycles before the write
	a_write_in_str: assert property (@(posedge clk) disable iff (reset)
		(mem_cmd == mem_write) |-> (state == st_str5) && $past(load_addr, 2));

	a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
		halt |=> halt && !reg_write && (mem_cmd != mem_write));

endmodule

`default_nettype wire

//--- source/register_file.sv
// general register file with one synchronous write port and one combinational read port
`default_nettype none

`include "cpu_settings.svh"

module register_file (
	input  wire                    clk,
	input  wire                    write,
	input  wire cpu_pkg::reg_num_t write_num,
	input  wire cpu_pkg::reg_num_t read_num,
	input  wire cpu_pkg::word_t    data_in,
	output cpu_pkg::word_t         data_out
);
	import cpu_pkg::*;

	word_t regs [`CPU_REG_COUNT];

	always_ff @(posedge clk) begin
		if (write) begin
			regs[write_num] <= data_in;
		end
	end

	assign data_out = regs[read_num]; // combinational read

	a_write_num_known: assert property (@(posedge clk)
		write |-> !$isunknown(write_num));

endmodule

`default_nettype wire

//--- source/datapath.sv
// operand registers, shifter, ALU, status flags and write-back selection
`default_nettype none

module datapath (
	input  wire                    clk,
	input  wire cpu_pkg::reg_num_t reg_num,
	input  wire                    reg_write,
	input  wire cpu_pkg::wb_sel_t  wb_sel,
	input  wire                    load_a,
	input  wire                    load_b,
	input  wire                    load_c,
	input  wire                    load_s,
	input  wire                    a_zero,
	input  wire                    b_imm,
	input  wire cpu_pkg::alu_op_t  alu_op,
	input  wire cpu_pkg::shift_t   shift,
	input  wire cpu_pkg::word_t    sximm5,
	input  wire cpu_pkg::word_t    sximm8,
	input  wire cpu_pkg::word_t    read_data,
	output cpu_pkg::word_t         c_out,
	output logic                   flag_z,
	output logic                   flag_n,
	output logic                   flag_v
);
	import cpu_pkg::*;

	word_t reg_out;
	word_t wb_data;
	word_t a_reg;
	word_t b_reg;
	word_t b_operand;
	word_t b_shifted;
	word_t a_in;
	word_t b_in;
	word_t alu_out;
	logic a_sign;
	logic b_sign;
	logic r_sign;
	logic alu_v;

	register_file u_regs (
		.clk       (clk),
		.write     (reg_write),
		.write_num (reg_num),
		.read_num  (reg_num),
		.data_in   (wb_data),
		.data_out  (reg_out)
	);

	always_ff @(posedge clk) begin
		if (load_a) a_reg <= reg_out;
		if (load_b) b_reg <= reg_out;
		if (load_c) c_out <= alu_out;
		if (load_s) begin
			flag_z <= (alu_out == '0);
			flag_n <= r_sign;
			flag_v <= alu_v;
		end
	end

	// B follows the read port in its own load cycle, so B and C can load together
	assign b_operand = load_b ? reg_out : b_reg;

	always_comb begin
		case (shift)
			shift_lsl: b_shifted = b_operand << 1;
			shift_lsr: b_shifted = b_operand >> 1;
			shift_asr: b_shifted = $signed(b_operand) >>> 1;
			default:   b_shifted = b_operand;
		endcase
	end

	assign a_in = a_zero ? '0 : a_reg; // MOV and MVN
	assign b_in = b_imm ? sximm5 : b_shifted; // base plus offset

	always_comb begin
		case (alu_op)
			alu_add: alu_out = a_in + b_in;
			alu_sub: alu_out = a_in - b_in;
			alu_and: alu_out = a_in & b_in;
			default: alu_out = ~b_in;
		endcase
	end

	assign a_sign = a_in[$bits(word_t)-1];
	assign b_sign = b_in[$bits(word_t)-1];
	assign r_sign = alu_out[$bits(word_t)-1];
	assign alu_v = (alu_op == alu_add) ? (a_sign == b_sign) && (r_sign != a_sign) :
		(alu_op == alu_sub) ? (a_sign != b_sign) && (r_sign != a_sign) : 1'b0;

	always_comb begin
		case (wb_sel)
			wb_imm:  wb_data = sximm8;
			wb_mem:  wb_data = read_data;
			default: wb_data = c_out;
		endcase
	end

endmodule

`default_nettype wire

//--- source/address_unit.sv
// program counter, next-PC selection, data address register and memory address selection
`default_nettype none

`include "cpu_settings.svh"

module address_unit (
	input  wire                 clk,
	input  wire                 load_pc,
	input  wire                 pc_reset,
	input  wire                 take_branch,
	input  wire                 load_addr,
	input  wire                 addr_sel_pc,
	input  wire cpu_pkg::word_t sximm8,
	input  wire cpu_pkg::word_t c_out,
	output cpu_pkg::addr_t      mem_addr
);
	import cpu_pkg::*;

	addr_t pc;
	addr_t next_pc;
	addr_t data_addr;

	always_comb begin
		if (pc_reset) begin
			next_pc = addr_t'(`CPU_RESET_PC);
		end else if (take_branch) begin
			next_pc = pc + sximm8[$bits(addr_t)-1:0]; // pc already holds PC + 1
		end else begin
			next_pc = pc + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_pc) begin
			pc <= next_pc;
		end
		if (load_addr) begin
			data_addr <= c_out[$bits(addr_t)-1:0];
		end
	end

	assign mem_addr = addr_sel_pc ? pc : data_addr; // PC while fetching

endmodule

`default_nettype wire

//--- source/cpu_top.sv
// processor top level connecting decoder, sequencer, datapath and address unit
`default_nettype none

module cpu_top (
	input  wire                 clk,
	input  wire                 reset,
	input  wire cpu_pkg::word_t read_data,
	output cpu_pkg::mem_cmd_t   mem_cmd,
	output cpu_pkg::addr_t      mem_addr,
	output cpu_pkg::word_t      write_data,
	output logic                halt
);
	import cpu_pkg::*;

	instr_class_t instr_class;
	reg_num_t reg_num;
	alu_op_t alu_op;
	shift_t shift;
	branch_cond_t cond;
	word_t sximm5;
	word_t sximm8;
	reg_sel_t reg_sel;
	wb_sel_t wb_sel;
	logic flag_z, flag_n, flag_v;
	logic load_a, load_b, load_c, load_s, reg_write, a_zero, b_imm;
	logic load_ir, load_pc, pc_reset, take_branch, load_addr, addr_sel_pc;

	instr_decoder u_decoder (
		.clk(clk), .reset(reset), .load_ir(load_ir), .reg_sel(reg_sel),
		.read_data(read_data), .instr_class(instr_class), .reg_num(reg_num),
		.alu_op(alu_op), .shift(shift), .cond(cond), .sximm5(sximm5), .sximm8(sximm8)
	);

	control_fsm u_fsm (
		.clk(clk), .reset(reset), .instr_class(instr_class), .cond(cond),
		.flag_z(flag_z), .flag_n(flag_n), .flag_v(flag_v),
		.reg_sel(reg_sel), .wb_sel(wb_sel), .load_a(load_a), .load_b(load_b),
		.load_c(load_c), .load_s(load_s), .reg_write(reg_write), .a_zero(a_zero),
		.b_imm(b_imm), .load_ir(load_ir), .load_pc(load_pc), .pc_reset(pc_reset),
		.take_branch(take_branch), .load_addr(load_addr), .addr_sel_pc(addr_sel_pc),
		.mem_cmd(mem_cmd), .halt(halt)
	);

	// C doubles as the store data
	datapath u_datapath (
		.clk(clk), .reg_num(reg_num), .reg_write(reg_write), .wb_sel(wb_sel),
		.load_a(load_a), .load_b(load_b), .load_c(load_c), .load_s(load_s),
		.a_zero(a_zero), .b_imm(b_imm), .alu_op(alu_op), .shift(shift),
		.sximm5(sximm5), .sximm8(sximm8), .read_data(read_data),
		.c_out(write_data), .flag_z(flag_z), .flag_n(flag_n), .flag_v(flag_v)
	);

	address_unit u_address (
		.clk(clk), .load_pc(load_pc), .pc_reset(pc_reset), .take_branch(take_branch),
		.load_addr(load_addr), .addr_sel_pc(addr_sel_pc), .sximm8(sximm8),
		.c_out(write_data), .mem_addr(mem_addr)
	);

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
// testbench clock and synchronous reset generator with a task that pulses reset again
`default_nettype none

module clock_gen (
	output logic clk,
	output logic reset
);
	localparam int half_period = 20;
	localparam int reset_cycles = 16;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	initial begin
		reset = 1'b1; // high from time zero
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
	end

	// reset changes only on the falling edge
	task automatic pulse_reset();
		@(negedge clk);
		reset = 1'b1;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
	endtask

endmodule

`default_nettype wire

//--- tests/cpu_tb.sv
// testbench with memory model, program loader, directed tests, compare tasks and timeout
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb;
	import cpu_pkg::*;

	localparam int mem_words = 1 << `CPU_ADDR_WIDTH;
	localparam int num_tests = 6;
	localparam int max_instr = 40;
	localparam int instr_cycles = 8; // STR with its fetch
	localparam int timeout_cycles = num_tests * max_instr * instr_cycles * 3 / 2 + 120;
	localparam int data_base = 100; // base address held in r7 and clear of the code
	localparam int watch_cycles = 50;
	localparam logic [2:0] opc_alu = 3'b101;
	localparam logic [2:0] opc_mov = 3'b110;
	localparam logic [2:0] opc_ldr = 3'b011;
	localparam logic [2:0] opc_str = 3'b100;
	localparam word_t halt_instr = 16'he000;

	logic clk;
	logic reset;
	word_t read_data;
	mem_cmd_t mem_cmd;
	addr_t mem_addr;
	word_t write_data;
	logic halt;

	word_t mem [mem_words];
	addr_t write_log [$];
	addr_t expected_writes [$];
	int load_at;
	int cycle_count = 0;
	integer seed = 32'h54dbc3d0;

	clock_gen clocks (.clk(clk), .reset(reset));

	cpu_top UUT (
		.clk        (clk),
		.reset      (reset),
		.read_data  (read_data),
		.mem_cmd    (mem_cmd),
		.mem_addr   (mem_addr),
		.write_data (write_data),
		.halt       (halt)
	);

	// same-cycle read and write at the rising edge
	assign read_data = (mem_cmd == mem_read) ? mem[mem_addr] : '0;

	always @(posedge clk) begin
		if (mem_cmd == mem_write) begin
			mem[mem_addr] <= write_data;
			write_log.push_back(mem_addr);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_cycles) begin
			report_failure($sformatf("timeout, the tests did not end within %0d cycles",
				timeout_cycles));
		end
	end

	function automatic word_t fill_word(int a);
		return word_t'(16'he000 | a); // a HALT carrying its own address
	endfunction

	function automatic word_t sext8(logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic word_t shifted(word_t v, logic [1:0] sh);
		case (sh)
			2'd1: return {v[14:0], 1'b0};
			2'd2: return {1'b0, v[15:1]};
			2'd3: return {v[15], v[15:1]};
			default: return v;
		endcase
	endfunction

	// branch outcome from the signed order of x and y
	function automatic bit condition_holds(logic [2:0] code, word_t x, word_t y);
		int sx;
		int sy;
		sx = $signed(x);
		sy = $signed(y);
		case (code)
			3'd0: return 1'b1;
			3'd1: return sx == sy;
			3'd2: return sx != sy;
			3'd3: return sx < sy;
			default: return sx <= sy;
		endcase
	endfunction

	function automatic word_t mov_imm_instr(reg_num_t rn, logic [7:0] imm);
		return {3'b110, 2'b10, rn, imm};
	endfunction

	function automatic word_t reg_instr(logic [2:0] opcode, logic [1:0] op, reg_num_t rn,
		reg_num_t rd, logic [1:0] sh, reg_num_t rm);
		return {opcode, op, rn, rd, sh, rm};
	endfunction

	function automatic word_t mem_instr(logic [2:0] opcode, reg_num_t rn, reg_num_t rd,
		logic [4:0] imm);
		return {opcode, 2'b00, rn, rd, imm};
	endfunction

	function automatic word_t branch_instr(logic [2:0] cond, logic [7:0] imm);
		return {3'b001, 2'b00, cond, imm};
	endfunction

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			report_failure($sformatf("Fail at time %0t: %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_addr(string name, addr_t expected, addr_t actual);
		if (actual !== expected) begin
			report_failure($sformatf("Fail at time %0t: %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_data(int offset, word_t expected);
		check_word($sformatf("mem[%0d]", data_base + offset), expected, mem[data_base + offset]);
	endtask

	task automatic check_write_order();
		if (write_log.size() != expected_writes.size()) begin
			report_failure($sformatf("%0d memory writes seen where %0d were expected",
				write_log.size(), expected_writes.size()));
		end
		foreach (expected_writes[i]) begin
			check_addr($sformatf("mem_addr of write %0d", i), expected_writes[i], write_log[i]);
		end
	endtask

	task automatic new_program();
		for (int a = 0; a < mem_words; a++) begin
			mem[a] = fill_word(a);
		end
		expected_writes.delete();
		load_at = 0;
	endtask

	task automatic emit(word_t instr);
		mem[load_at] = instr;
		load_at++;
	endtask

	task automatic expect_write(int offset);
		expected_writes.push_back(addr_t'(data_base + offset));
	endtask

	task automatic emit_store(reg_num_t rd, int offset);
		emit(mem_instr(opc_str, 3'd7, rd, 5'(offset)));
		expect_write(offset);
	endtask

	task automatic wait_halt();
		do @(negedge clk); while (halt !== 1'b1);
	endtask

	task automatic run_program();
		write_log.delete();
		clocks.pulse_reset();
		wait_halt();
	endtask

	task automatic test_load_store();
		logic [7:0] imm [6];
		new_program();
		emit(mov_imm_instr(3'd7, 8'(data_base)));
		for (int r = 0; r < 6; r++) begin
			imm[r] = 8'($random(seed));
			emit(mov_imm_instr(r[2:0], imm[r]));
		end
		for (int r = 0; r < 6; r++) begin
			emit_store(r[2:0], r);
		end
		emit(halt_instr);
		run_program();
		check_write_order();
		for (int r = 0; r < 6; r++) begin
			check_data(r, sext8(imm[r]));
		end
	endtask

	task automatic test_alu_shifts();
		logic [7:0] a_val;
		logic [7:0] b_val;
		word_t a;
		word_t b;
		new_program();
		a_val = 8'($random(seed));
		b_val = 8'($random(seed)) | 8'h80; // negative so LSR and ASR differ
		a = sext8(a_val);
		b = sext8(b_val);
		emit(mov_imm_instr(3'd7, 8'(data_base)));
		emit(mov_imm_instr(3'd0, a_val));
		emit(mov_imm_instr(3'd1, b_val));
		for (int sh = 0; sh < 4; sh++) begin
			emit(reg_instr(opc_alu, 2'b00, 3'd0, 3'd2, sh[1:0], 3'd1)); // ADD r2
			emit_store(3'd2, 4 * sh);
			emit(reg_instr(opc_alu, 2'b10, 3'd0, 3'd3, sh[1:0], 3'd1)); // AND r3
			emit_store(3'd3, 4 * sh + 1);
			emit(reg_instr(opc_alu, 2'b11, 3'd0, 3'd4, sh[1:0], 3'd1)); // MVN r4
			emit_store(3'd4, 4 * sh + 2);
			emit(reg_instr(opc_mov, 2'b00, 3'd0, 3'd5, sh[1:0], 3'd1)); // MOV r5
			emit_store(3'd5, 4 * sh + 3);
		end
		emit(halt_instr);
		run_program();
		check_write_order();
		for (int sh = 0; sh < 4; sh++) begin
			check_data(4 * sh, a + shifted(b, sh[1:0]));
			check_data(4 * sh + 1, a & shifted(b, sh[1:0]));
			check_data(4 * sh + 2, ~shifted(b, sh[1:0]));
			check_data(4 * sh + 3, shifted(b, sh[1:0]));
		end
	endtask

	task automatic test_load_word();
		int src [4];
		word_t data [4];
		new_program();
		src = '{-3, 0, 15, -16}; // offsets at both imm5 limits
		emit(mov_imm_instr(3'd7, 8'(data_base)));
		for (int i = 0; i < 4; i++) begin
			data[i] = word_t'($random(seed));
			mem[data_base + src[i]] = data[i];
			emit(mem_instr(opc_ldr, 3'd7, i[2:0], 5'(src[i])));
			emit_store(i[2:0], 5 + i);
		end
		emit(halt_instr);
		run_program();
		check_write_order();
		for (int i = 0; i < 4; i++) begin
			check_data(5 + i, data[i]);
		end
	endtask

	task automatic test_branches();
		logic [7:0] x [5];
		logic [7:0] y [5];
		bit taken [5];
		new_program();
		emit(mov_imm_instr(3'd7, 8'(data_base)));
		emit(mov_imm_instr(3'd6, 8'h5a)); // marker
		for (int c = 0; c < 5; c++) begin
			x[c] = 8'($random(seed));
			y[c] = ($random(seed) & 1) ? x[c] : 8'($random(seed)); // equal half the time
			taken[c] = condition_holds(c[2:0], sext8(x[c]), sext8(y[c]));
			emit(mov_imm_instr(3'd0, x[c]));
			emit(mov_imm_instr(3'd1, y[c]));
			emit(reg_instr(opc_alu, 2'b01, 3'd0, 3'd0, 2'b00, 3'd1)); // CMP r0, r1
			emit(branch_instr(c[2:0], 8'd1)); // over the next STR
			emit(mem_instr(opc_str, 3'd7, 3'd6, 5'(c)));
			if (!taken[c]) begin
				expect_write(c);
			end
		end
		emit(halt_instr);
		run_program();
		check_write_order();
		for (int c = 0; c < 5; c++) begin
			check_data(c, taken[c] ? fill_word(data_base + c) : 16'h005a);
		end
	endtask

	task automatic test_halt_holds();
		logic [7:0] v;
		int writes;
		new_program();
		v = 8'($random(seed));
		emit(mov_imm_instr(3'd7, 8'(data_base)));
		emit(mov_imm_instr(3'd0, v));
		emit_store(3'd0, 0);
		emit(halt_instr);
		emit(mem_instr(opc_str, 3'd7, 3'd0, 5'd1)); // never reached
		run_program();
		writes = write_log.size();
		repeat (watch_cycles) begin
			@(negedge clk);
			if (halt !== 1'b1) begin
				report_failure("halt went low while the processor was halted");
			end
			if (mem_cmd == mem_write) begin
				report_failure("memory write command issued while halted");
			end
		end
		if (write_log.size() != writes) begin
			report_failure("memory was written after HALT");
		end
		check_write_order();
		check_data(0, sext8(v));
		check_data(1, fill_word(data_base + 1));
	endtask

	task automatic test_reset_restart();
		logic [7:0] a;
		logic [7:0] b;
		new_program();
		a = 8'($random(seed));
		b = 8'($random(seed));
		emit(mov_imm_instr(3'd7, 8'(data_base)));
		emit(mov_imm_instr(3'd0, a));
		emit(mov_imm_instr(3'd1, b));
		emit(reg_instr(opc_alu, 2'b00, 3'd0, 3'd2, 2'b00, 3'd1)); // ADD r2
		emit_store(3'd2, 0);
		emit(reg_instr(opc_alu, 2'b10, 3'd0, 3'd3, 2'b01, 3'd1)); // AND r3, LSL
		emit_store(3'd3, 1);
		emit(reg_instr(opc_alu, 2'b11, 3'd0, 3'd4, 2'b10, 3'd1)); // MVN r4, LSR
		emit_store(3'd4, 2);
		emit(halt_instr);
		write_log.delete();
		clocks.pulse_reset();
		do @(negedge clk); while (write_log.size() == 0);
		clocks.pulse_reset(); // restart after the first store
		for (int i = 0; i < 3; i++) begin
			mem[data_base + i] = fill_word(data_base + i);
		end
		write_log.delete();
		do @(negedge clk); while (mem_cmd != mem_read);
		check_addr("mem_addr", addr_t'(`CPU_RESET_PC), mem_addr);
		wait_halt();
		check_write_order();
		check_data(0, sext8(a) + sext8(b));
		check_data(1, sext8(a) & shifted(sext8(b), 2'd1));
		check_data(2, ~shifted(sext8(b), 2'd2));
	endtask

	initial begin
		for (int a = 0; a < mem_words; a++) begin
			mem[a] = fill_word(a);
		end
		wait_halt(); // the fill decodes as HALT
		test_load_store();
		test_alu_shifts();
		test_load_word();
		test_branches();
		test_halt_holds();
		test_reset_restart();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
source/cpu_pkg.sv
source/instr_decoder.sv
source/control_fsm.sv
source/register_file.sv
source/datapath.sv
source/address_unit.sv
source/cpu_top.sv
tests/clock_gen.sv
tests/cpu_tb.sv
